//--- rtl/scan_pkg.sv
package scan_pkg;

  // Width of one saved DFA state
  localparam int DFA_W = 2;

  // APB bus widths
  localparam int APB_AW = 8;
  localparam int APB_DW = 32;

  // Default number of streams, legal range 2 to 64
  localparam int STREAMS_DEF = 64;

  // Default width of the hit packet count
  localparam int COUNT_W_DEF = 16;

  // Signature bytes, "SMB"
  localparam logic [7:0] SIG_B0 = 8'h53;
  localparam logic [7:0] SIG_B1 = 8'h4D;
  localparam logic [7:0] SIG_B2 = 8'h42;

  // DFA states
  // Each state records how much of the signature has been seen
  typedef enum logic [DFA_W-1:0] {
    S_IDLE   = 2'd0,
    S_GOT_S  = 2'd1,
    S_GOT_SM = 2'd2,
    S_MATCH  = 2'd3
  } dfa_state_e;

  // APB register offsets
  typedef enum logic [APB_AW-1:0] {
    // Enable bitmap, streams 0 to 31
    REG_EN_LO  = 8'h00,
    // Enable bitmap, streams 32 to 63
    REG_EN_HI  = 8'h04,
    // Hit packet count, write clears
    REG_COUNT  = 8'h08,
    // Bit 0 holds the hit of the last packet
    REG_STATUS = 8'h0C
  } reg_addr_e;

endpackage

//--- rtl/dfa_ctx_if.sv
interface dfa_ctx_if;

  // State restore, one cycle pulse after sop
  logic                   restore_vld;
  scan_pkg::dfa_state_e   restore_state;

  // Live DFA state, saved at eop
  scan_pkg::dfa_state_e   cur_state;

  // Signature found
  logic                   accept;

  // Context memory side
  modport ctx (
    output restore_vld,
    output restore_state,
    input  cur_state
  );

  // Matcher side
  modport dfa (
    input  restore_vld,
    input  restore_state,
    output cur_state,
    output accept
  );

  // Counter only watches packet start and matches
  modport cnt (
    input  accept,
    input  restore_vld
  );

endinterface

//--- rtl/dfa_matcher.sv
module dfa_matcher (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       byte_vld,
  input  logic [7:0] byte_data,
  dfa_ctx_if.dfa     ctx
);

  // Input byte stage
  logic                 byte_vld_r;
  logic [7:0]           byte_r;

  // DFA state and accept flag
  scan_pkg::dfa_state_e state_q;
  scan_pkg::dfa_state_e state_nxt;
  logic                 accept_q;

  // One step of the signature automaton
  function automatic scan_pkg::dfa_state_e dfa_step(
    input scan_pkg::dfa_state_e s,
    input logic [7:0]           b
  );
    scan_pkg::dfa_state_e fallback;
    // A mismatching 'S' may start a new signature
    fallback = (b == scan_pkg::SIG_B0) ? scan_pkg::S_GOT_S : scan_pkg::S_IDLE;
    case (s)
      scan_pkg::S_GOT_S:
        dfa_step = (b == scan_pkg::SIG_B1) ? scan_pkg::S_GOT_SM : fallback;
      scan_pkg::S_GOT_SM:
        dfa_step = (b == scan_pkg::SIG_B2) ? scan_pkg::S_MATCH : fallback;
      // Idle and match both restart the search
      default:
        dfa_step = fallback;
    endcase
  endfunction

  // Register the byte before it reaches the DFA
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      byte_vld_r <= 1'b0;
    else
      byte_vld_r <= byte_vld;
  end

  always_ff @(posedge clk)
  begin
    byte_r <= byte_data;
  end

  assign state_nxt = dfa_step(state_q, byte_r);

  // Restore wins over stepping
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q  <= scan_pkg::S_IDLE;
      accept_q <= 1'b0;
    end
    else if (ctx.restore_vld)
    begin
      state_q  <= ctx.restore_state;
      // Drop any accept left from the previous packet
      accept_q <= 1'b0;
    end
    else
    begin
      if (byte_vld_r)
        state_q <= state_nxt;
      // Single cycle pulse per completed signature
      accept_q <= byte_vld_r && (state_nxt == scan_pkg::S_MATCH);
    end
  end

  assign ctx.cur_state = state_q;
  assign ctx.accept    = accept_q;

  // Bytes never reach the DFA while a restore is in flight
  a_no_restore_on_byte: assert property (
    @(posedge clk) disable iff (!rst_n) !(ctx.restore_vld && byte_vld_r)
  );

endmodule

//--- rtl/stream_context.sv
module stream_context #(
  parameter int STREAMS = scan_pkg::STREAMS_DEF
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       sop,
  input  logic                       eop,
  input  logic                       new_stream,
  input  logic [$clog2(STREAMS)-1:0] stream_id,
  input  logic                       save_en,
  dfa_ctx_if.ctx                     ctx
);

  // Saved DFA state, one entry per stream
  logic [scan_pkg::DFA_W-1:0] state_mem [STREAMS];

  logic                       restore_vld_q;
  scan_pkg::dfa_state_e       restore_state_q;

  // Restore pulse follows sop by one cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      restore_vld_q <= 1'b0;
    else
      restore_vld_q <= sop;
  end

  // New streams begin from idle, others resume where they stopped
  always_ff @(posedge clk)
  begin
    if (sop)
    begin
      if (new_stream)
        restore_state_q <= scan_pkg::S_IDLE;
      else
        restore_state_q <= scan_pkg::dfa_state_e'(state_mem[stream_id]);
    end
  end

  // Save at packet end, only for enabled streams
  always_ff @(posedge clk)
  begin
    if (eop && save_en)
      state_mem[stream_id] <= ctx.cur_state;
  end

  assign ctx.restore_vld   = restore_vld_q;
  assign ctx.restore_state = restore_state_q;

  // A read and a save of the memory never share a cycle
  a_sop_eop_apart: assert property (
    @(posedge clk) disable iff (!rst_n) !(sop && eop)
  );

endmodule

//--- rtl/hit_counter.sv
module hit_counter #(
  parameter int COUNT_W = scan_pkg::COUNT_W_DEF
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               eop,
  input  logic               enable,
  input  logic               clear,
  dfa_ctx_if.cnt             ctx,
  output logic [COUNT_W-1:0] count,
  output logic               hit_vld,
  output logic               hit
);

  // Set once any match is seen in the current packet
  logic pkt_hit;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      pkt_hit <= 1'b0;
    else if (ctx.restore_vld)
      pkt_hit <= 1'b0;
    else if (ctx.accept)
      pkt_hit <= 1'b1;
  end

  // Packet result, disabled streams never report a hit
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      hit_vld <= 1'b0;
      hit     <= 1'b0;
    end
    else
    begin
      hit_vld <= eop;
      if (eop)
        hit <= pkt_hit && enable;
    end
  end

  // Clear has priority; count sticks at all ones
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      count <= '0;
    else if (clear)
      count <= '0;
    else if (eop && enable && (count != '1))
      count <= count + COUNT_W'(pkt_hit);
  end

endmodule

//--- rtl/apb_regs.sv
module apb_regs #(
  parameter int STREAMS = scan_pkg::STREAMS_DEF,
  parameter int COUNT_W = scan_pkg::COUNT_W_DEF
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [scan_pkg::APB_AW-1:0] paddr,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [scan_pkg::APB_DW-1:0] pwdata,
  output logic [scan_pkg::APB_DW-1:0] prdata,
  output logic                        pready,
  output logic                        pslverr,
  input  logic [$clog2(STREAMS)-1:0]  stream_id,
  input  logic [COUNT_W-1:0]          count,
  input  logic                        last_hit,
  output logic                        stream_en,
  output logic                        count_clear
);

  // Enable bitmap halves
  logic [31:0] en_lo;
  logic [31:0] en_hi;
  logic [63:0] en_all;

  logic        access;
  logic        addr_ok;

  // Zero wait, so the access phase is the only phase that matters
  assign access = psel && penable;
  assign pready = 1'b1;

  // Read mux and address decode
  always_comb
  begin
    prdata  = '0;
    addr_ok = 1'b1;
    case (paddr)
      scan_pkg::REG_EN_LO:  prdata = en_lo;
      scan_pkg::REG_EN_HI:  prdata = en_hi;
      scan_pkg::REG_COUNT:  prdata[COUNT_W-1:0] = count;
      scan_pkg::REG_STATUS: prdata[0] = last_hit;
      default:              addr_ok = 1'b0;
    endcase
  end

  assign pslverr = access && !addr_ok;

  // Any write to the count register clears it
  assign count_clear = access && pwrite && (paddr == scan_pkg::REG_COUNT);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      en_lo <= '0;
      en_hi <= '0;
    end
    else if (access && pwrite)
    begin
      if (paddr == scan_pkg::REG_EN_LO)
        en_lo <= pwdata;
      if (paddr == scan_pkg::REG_EN_HI)
        en_hi <= pwdata;
    end
  end

  // Bit for the stream currently on the bus
  assign en_all    = {en_hi, en_lo};
  assign stream_en = en_all[stream_id];

  a_penable_needs_psel: assert property (
    @(posedge clk) disable iff (!rst_n) penable |-> psel
  );

endmodule

//--- rtl/packet_scanner.sv
module packet_scanner #(
  parameter int STREAMS = scan_pkg::STREAMS_DEF,
  parameter int COUNT_W = scan_pkg::COUNT_W_DEF
) (
  input  logic                        clk,
  input  logic                        rst_n,
  // Byte stream
  input  logic                        sop,
  input  logic [$clog2(STREAMS)-1:0]  stream_id,
  input  logic                        new_stream,
  input  logic                        byte_vld,
  input  logic [7:0]                  byte_data,
  input  logic                        eop,
  // Per packet result
  output logic                        hit_vld,
  output logic                        hit,
  // APB slave
  input  logic [scan_pkg::APB_AW-1:0] paddr,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [scan_pkg::APB_DW-1:0] pwdata,
  output logic [scan_pkg::APB_DW-1:0] prdata,
  output logic                        pready,
  output logic                        pslverr
);

  // Enable bit of the current stream, gates both save and count
  logic               stream_en;
  logic               count_clear;
  logic [COUNT_W-1:0] count;

  dfa_ctx_if ctx_if ();

  dfa_matcher dfa_matcher_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .byte_vld  (byte_vld),
    .byte_data (byte_data),
    .ctx       (ctx_if.dfa)
  );

  stream_context #(
    .STREAMS (STREAMS)
  ) stream_context_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .sop        (sop),
    .eop        (eop),
    .new_stream (new_stream),
    .stream_id  (stream_id),
    .save_en    (stream_en),
    .ctx        (ctx_if.ctx)
  );

  hit_counter #(
    .COUNT_W (COUNT_W)
  ) hit_counter_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .eop     (eop),
    .enable  (stream_en),
    .clear   (count_clear),
    .ctx     (ctx_if.cnt),
    .count   (count),
    .hit_vld (hit_vld),
    .hit     (hit)
  );

  // The held hit output doubles as the status bit
  apb_regs #(
    .STREAMS (STREAMS),
    .COUNT_W (COUNT_W)
  ) apb_regs_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .stream_id   (stream_id),
    .count       (count),
    .last_hit    (hit),
    .stream_en   (stream_en),
    .count_clear (count_clear)
  );

endmodule

//--- test/packet_scanner_tb.sv
module packet_scanner_tb;

  localparam int STREAMS = 64;
  localparam int COUNT_W = 16;
  localparam int ID_W    = $clog2(STREAMS);
  // Run limit well above the length of all tests
  localparam int MAX_CYCLES = 4000;

  logic            clk = 1'b0;
  logic            rst_n;
  logic            sop;
  logic [ID_W-1:0] stream_id;
  logic            new_stream;
  logic            byte_vld;
  logic [7:0]      byte_data;
  logic            eop;
  logic            hit_vld;
  logic            hit;
  logic [7:0]      paddr;
  logic            psel;
  logic            penable;
  logic            pwrite;
  logic [31:0]     pwdata;
  logic [31:0]     prdata;
  logic            pready;
  logic            pslverr;

  // Reference model with the state kept as matched prefix length 0 to 3
  int unsigned        model_state [STREAMS];
  logic [63:0]        model_en;
  logic [COUNT_W-1:0] model_count;
  logic               model_last_hit;

  // Expected values seen by the checkers
  logic        exp_hit;
  logic [31:0] exp_rdata;
  logic        exp_rd_chk;
  logic        exp_err;

  logic [31:0] rng;
  logic [7:0]  pkt_q [$];
  int          cycles = 0;
  int          errors = 0;
  int          err_mark;
  int          tests_ok;
  int          tests_bad;

  packet_scanner #(
    .STREAMS (STREAMS),
    .COUNT_W (COUNT_W)
  ) packet_scanner_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .sop        (sop),
    .stream_id  (stream_id),
    .new_stream (new_stream),
    .byte_vld   (byte_vld),
    .byte_data  (byte_data),
    .eop        (eop),
    .hit_vld    (hit_vld),
    .hit        (hit),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr)
  );

  always #20 clk = ~clk;

  // Packet result against the model
  a_hit_value: assert property (@(posedge clk) disable iff (!rst_n) hit_vld |-> hit == exp_hit)
  else
  begin
    errors++;
    $display("FAIL at %0t: hit is %0b, expected %0b", $time, $sampled(hit), exp_hit);
  end

  // One result pulse per eop and none otherwise
  a_hit_pulse: assert property (@(posedge clk) disable iff (!rst_n) hit_vld == $past(eop))
  else
  begin
    errors++;
    $display("FAIL at %0t: hit_vld %0b does not follow eop", $time, $sampled(hit_vld));
  end

  a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && penable && !pwrite && exp_rd_chk) |-> prdata == exp_rdata)
  else
  begin
    errors++;
    $display("FAIL at %0t: prdata %08h at 0x%02h, expected %08h",
             $time, $sampled(prdata), paddr, exp_rdata);
  end

  // Error only in the access phase of an unmapped address
  a_slave_error: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr == (psel && penable && exp_err))
  else
  begin
    errors++;
    $display("FAIL at %0t: pslverr is %0b at 0x%02h", $time, $sampled(pslverr), paddr);
  end

  a_ready: assert property (@(posedge clk) disable iff (!rst_n) pready)
  else
  begin
    errors++;
    $display("FAIL at %0t: pready is low", $time);
  end

  // Hang guard
  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Signature progress on one byte
  function automatic int unsigned step_model(input int unsigned len, input logic [7:0] b);
    logic [7:0] want;
    case (len)
      1: want = "M";
      2: want = "B";
      default: want = "S";
    endcase
    if (len < 3 && b == want)
      return len + 1;
    // A stray 'S' may begin a new signature
    else if (b == "S")
      return 1;
    else
      return 0;
  endfunction

  function automatic logic addr_known(input logic [7:0] a);
    return a inside {scan_pkg::REG_EN_LO, scan_pkg::REG_EN_HI,
                     scan_pkg::REG_COUNT, scan_pkg::REG_STATUS};
  endfunction

  function automatic logic [31:0] expected_read(input logic [7:0] a);
    case (a)
      scan_pkg::REG_EN_LO:  return model_en[31:0];
      scan_pkg::REG_EN_HI:  return model_en[63:32];
      scan_pkg::REG_COUNT:  return 32'(model_count);
      scan_pkg::REG_STATUS: return {31'b0, model_last_hit};
      default:              return 32'h0;
    endcase
  endfunction

  // Random filler never holds 'S' so no signature forms by accident
  task next_filler(output logic [7:0] b);
    do
    begin
      rng = xorshift32(rng);
      b   = rng[7:0];
    end
    while (b == "S");
  endtask

  task add_filler(input int n);
    logic [7:0] b;
    repeat (n)
    begin
      next_filler(b);
      pkt_q.push_back(b);
    end
  endtask

  task add_text(input string s);
    for (int i = 0; i < s.len(); i++)
      pkt_q.push_back(s[i]);
  endtask

  // Sends the queued bytes as one packet and updates the model
  task send_packet(input logic [ID_W-1:0] id, input logic fresh);
    int unsigned st;
    logic        pkt_hit;
    st      = fresh ? 0 : model_state[id];
    pkt_hit = 1'b0;
    @(negedge clk);
    sop        = 1'b1;
    stream_id  = id;
    new_stream = fresh;
    @(negedge clk);
    sop        = 1'b0;
    new_stream = 1'b0;
    // Second cycle before the first byte
    @(negedge clk);
    foreach (pkt_q[i])
    begin
      byte_vld  = 1'b1;
      byte_data = pkt_q[i];
      st = step_model(st, pkt_q[i]);
      if (st == 3)
        pkt_hit = 1'b1;
      @(negedge clk);
    end
    byte_vld  = 1'b0;
    byte_data = 8'h00;
    // eop three cycles after the last byte
    repeat (2) @(negedge clk);
    exp_hit = pkt_hit && model_en[id];
    if (model_en[id])
    begin
      model_state[id] = st;
      if (pkt_hit && model_count != '1)
        model_count++;
    end
    model_last_hit = exp_hit;
    eop = 1'b1;
    @(negedge clk);
    eop = 1'b0;
    while (!hit_vld)
      @(negedge clk);
    @(negedge clk);
    pkt_q.delete();
  endtask

  task apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk);
    psel       = 1'b1;
    penable    = 1'b0;
    pwrite     = 1'b1;
    paddr      = addr;
    pwdata     = data;
    exp_err    = !addr_known(addr);
    exp_rd_chk = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    while (!pready)
      @(posedge clk);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    case (addr)
      scan_pkg::REG_EN_LO: model_en[31:0] = data;
      scan_pkg::REG_EN_HI: model_en[63:32] = data;
      scan_pkg::REG_COUNT: model_count = '0;
      default: ;
    endcase
  endtask

  task apb_read(input logic [7:0] addr);
    @(negedge clk);
    psel       = 1'b1;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = addr;
    exp_err    = !addr_known(addr);
    exp_rd_chk = addr_known(addr);
    exp_rdata  = expected_read(addr);
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    while (!pready)
      @(posedge clk);
    @(negedge clk);
    psel       = 1'b0;
    penable    = 1'b0;
    exp_rd_chk = 1'b0;
  endtask

  task report_test(input int num, input string name);
    if (errors == err_mark)
    begin
      tests_ok++;
      $display("[test %0d] %s: ok", num, name);
    end
    else
    begin
      tests_bad++;
      $display("[test %0d] %s: %0d errors", num, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  initial
  begin
    rst_n          = 1'b0;
    sop            = 1'b0;
    stream_id      = '0;
    new_stream     = 1'b0;
    byte_vld       = 1'b0;
    byte_data      = 8'h00;
    eop            = 1'b0;
    paddr          = 8'h00;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    pwdata         = 32'h0;
    exp_hit        = 1'b0;
    exp_rdata      = 32'h0;
    exp_rd_chk     = 1'b0;
    exp_err        = 1'b0;
    model_en       = '0;
    model_count    = '0;
    model_last_hit = 1'b0;
    rng            = 32'd16817;
    err_mark       = 0;
    tests_ok       = 0;
    tests_bad      = 0;
    foreach (model_state[i])
      model_state[i] = 0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // Everything clear out of reset
    apb_read(scan_pkg::REG_EN_LO);
    apb_read(scan_pkg::REG_EN_HI);
    apb_read(scan_pkg::REG_COUNT);
    apb_read(scan_pkg::REG_STATUS);
    repeat (4) @(negedge clk);
    report_test(1, "reset values");

    // Stream 3 enabled and the second packet holds two matches
    apb_write(scan_pkg::REG_EN_LO, 32'h0000_0008);
    add_filler(5);
    add_text("SMB");
    add_filler(4);
    send_packet(6'd3, 1'b1);
    apb_read(scan_pkg::REG_COUNT);
    add_filler(3);
    add_text("SMB");
    add_filler(2);
    add_text("SMB");
    add_filler(3);
    send_packet(6'd3, 1'b0);
    apb_read(scan_pkg::REG_COUNT);
    apb_read(scan_pkg::REG_STATUS);
    report_test(2, "match on enabled stream");

    // Split on stream 5 with stream 9 in between
    apb_write(scan_pkg::REG_EN_LO, 32'h0000_0228);
    add_filler(4);
    add_text("SM");
    send_packet(6'd5, 1'b1);
    add_filler(6);
    send_packet(6'd9, 1'b1);
    add_text("B");
    add_filler(4);
    send_packet(6'd5, 1'b0);
    apb_read(scan_pkg::REG_COUNT);
    report_test(3, "split across packets");

    // Same split but the second packet starts a new stream
    add_filler(3);
    add_text("SM");
    send_packet(6'd5, 1'b0);
    add_text("B");
    add_filler(3);
    send_packet(6'd5, 1'b1);
    apb_read(scan_pkg::REG_STATUS);
    apb_read(scan_pkg::REG_COUNT);
    report_test(4, "split with new stream");

    // Stream 12 gets a saved idle state and is then disabled
    apb_write(scan_pkg::REG_EN_LO, 32'h0000_1228);
    add_filler(4);
    send_packet(6'd12, 1'b1);
    apb_write(scan_pkg::REG_EN_LO, 32'h0000_0228);
    add_filler(2);
    add_text("SMB");
    add_filler(2);
    send_packet(6'd12, 1'b0);
    apb_read(scan_pkg::REG_COUNT);
    add_filler(3);
    add_text("SM");
    send_packet(6'd12, 1'b0);
    apb_write(scan_pkg::REG_EN_LO, 32'h0000_1228);
    add_text("B");
    add_filler(3);
    send_packet(6'd12, 1'b0);
    apb_read(scan_pkg::REG_COUNT);
    apb_read(scan_pkg::REG_STATUS);
    report_test(5, "disabled stream");

    // Count clear followed by a bad offset and the upper enable word
    apb_write(scan_pkg::REG_COUNT, 32'hDEAD_BEEF);
    apb_read(scan_pkg::REG_COUNT);
    apb_read(8'h10);
    apb_write(8'h10, 32'h0000_0001);
    apb_write(scan_pkg::REG_EN_HI, 32'h0000_0100);
    apb_read(scan_pkg::REG_EN_HI);
    add_filler(4);
    add_text("SMB");
    add_filler(2);
    send_packet(6'd40, 1'b1);
    apb_read(scan_pkg::REG_COUNT);
    apb_read(scan_pkg::REG_STATUS);
    report_test(6, "register access");

    $display("Summary: %0d tests ok, %0d tests with errors, %0d errors in total",
             tests_ok, tests_bad, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- verilog.f
rtl/scan_pkg.sv
rtl/dfa_ctx_if.sv
rtl/dfa_matcher.sv
rtl/stream_context.sv
rtl/hit_counter.sv
rtl/apb_regs.sv
rtl/packet_scanner.sv
test/packet_scanner_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the packet scanner testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module packet_scanner_tb -Mdir obj_dir -f verilog.f

./obj_dir/Vpacket_scanner_tb | tee sim.log

# Pass only when the testbench reported it
grep -q "^TEST PASSED$" sim.log
